// File: hw/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	typedef logic [31:0] uint32_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [3:0]  byte_en_t;

	typedef enum logic [5:0] {
		OP_LUI, OP_AND, OP_OR, OP_XOR, OP_NOR,
		OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_SLT, OP_SLTU,
		OP_CLZ, OP_CLO,
		OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV,
		OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_BLTZ, OP_BGEZ,
		OP_BLTZAL, OP_BGEZAL, OP_J, OP_JAL, OP_JR, OP_JALR,
		OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_SB, OP_SH, OP_SW,
		OP_SYSCALL, OP_BREAK, OP_ERET, OP_INVALID
	} oper_t;

	// mips cause register encodings
	typedef enum logic [4:0] {
		EXC_ADEL = 5'h04,
		EXC_ADES = 5'h05,
		EXC_SYS  = 5'h08,
		EXC_BP   = 5'h09,
		EXC_RI   = 5'h0a,
		EXC_CPU  = 5'h0b,
		EXC_OV   = 5'h0c
	} exc_code_t;

	typedef enum logic {
		IDLE,
		HOLD
	} stage_state_t;

	typedef struct packed {
		uint32_t instruction;
		uint32_t pc;
		uint32_t reg1;
		uint32_t reg2;
		logic    is_usermode;
	} exec_req_t;

	typedef struct packed {
		oper_t     op;
		reg_addr_t rd;
		uint32_t   imm;
		logic [4:0] shamt;
		logic      is_load;
		logic      is_store;
		logic      is_priv;
		logic      link;
	} decoded_t;

	typedef struct packed {
		logic     read;
		logic     write;
		uint32_t  vaddr;
		uint32_t  wrdata;
		byte_en_t byteenable;
	} memreq_t;

	typedef struct packed {
		logic      valid;
		exc_code_t exc_code;
		uint32_t   badvaddr;
	} exception_t;

	typedef struct packed {
		logic    taken;
		uint32_t target;
	} branch_resolved_t;

	typedef struct packed {
		logic             valid;
		uint32_t          result;
		reg_addr_t        rd;
		logic             eret;
		memreq_t          memreq;
		exception_t       ex;
		branch_resolved_t branch;
	} exec_result_t;

endpackage

`default_nettype wire

// File: hw/count_bit.sv
`default_nettype none
`timescale 1ns/10ps

module count_bit (
	input  logic             bit_val,
	input  cpu_pkg::uint32_t val,
	output cpu_pkg::uint32_t count
);

	// highest mismatching bit wins
	always_comb begin
		count = 32'd32;
		for (int i = 0; i < 32; i++) begin
			if (val[i] != bit_val)
				count = 32'd31 - 32'(i);
		end
	end

endmodule

`default_nettype wire

// File: hw/instr_decode.sv
`default_nettype none
`timescale 1ns/10ps

module instr_decode (
	input  cpu_pkg::uint32_t  instruction,
	output cpu_pkg::decoded_t decoded
);
	import cpu_pkg::*;

	logic [5:0] opcode, funct;
	reg_addr_t rt, rd_field, rd;
	logic is_special;
	oper_t op;
	uint32_t imm;

	assign opcode     = instruction[31:26];
	assign funct      = instruction[5:0];
	assign rt         = instruction[20:16];
	assign rd_field   = instruction[15:11];
	assign is_special = (opcode == 6'h00);

	always_comb begin
		op = OP_INVALID;
		case (opcode)
			6'h00: begin
				case (funct)
					6'h00: op = OP_SLL;
					6'h02: op = OP_SRL;
					6'h03: op = OP_SRA;
					6'h04: op = OP_SLLV;
					6'h06: op = OP_SRLV;
					6'h07: op = OP_SRAV;
					6'h08: op = OP_JR;
					6'h09: op = OP_JALR;
					6'h0c: op = OP_SYSCALL;
					6'h0d: op = OP_BREAK;
					6'h20: op = OP_ADD;
					6'h21: op = OP_ADDU;
					6'h22: op = OP_SUB;
					6'h23: op = OP_SUBU;
					6'h24: op = OP_AND;
					6'h25: op = OP_OR;
					6'h26: op = OP_XOR;
					6'h27: op = OP_NOR;
					6'h2a: op = OP_SLT;
					6'h2b: op = OP_SLTU;
					default: op = OP_INVALID;
				endcase
			end
			// regimm, selected by rt
			6'h01: begin
				case (rt)
					5'h00: op = OP_BLTZ;
					5'h01: op = OP_BGEZ;
					5'h10: op = OP_BLTZAL;
					5'h11: op = OP_BGEZAL;
					default: op = OP_INVALID;
				endcase
			end
			6'h02: op = OP_J;
			6'h03: op = OP_JAL;
			6'h04: op = OP_BEQ;
			6'h05: op = OP_BNE;
			6'h06: op = OP_BLEZ;
			6'h07: op = OP_BGTZ;
			6'h08: op = OP_ADD;
			6'h09: op = OP_ADDU;
			6'h0a: op = OP_SLT;
			6'h0b: op = OP_SLTU;
			6'h0c: op = OP_AND;
			6'h0d: op = OP_OR;
			6'h0e: op = OP_XOR;
			6'h0f: op = OP_LUI;
			// cop0 only knows eret here
			6'h10: begin
				if (instruction[25] && funct == 6'h18)
					op = OP_ERET;
			end
			6'h1c: begin
				if (funct == 6'h20)
					op = OP_CLZ;
				else if (funct == 6'h21)
					op = OP_CLO;
			end
			6'h20: op = OP_LB;
			6'h21: op = OP_LH;
			6'h23: op = OP_LW;
			6'h24: op = OP_LBU;
			6'h25: op = OP_LHU;
			6'h28: op = OP_SB;
			6'h29: op = OP_SH;
			6'h2b: op = OP_SW;
			default: op = OP_INVALID;
		endcase
	end

	always_comb begin
		case (op)
			OP_JAL, OP_BLTZAL, OP_BGEZAL: rd = 5'd31;
			OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LUI: rd = rt;
			OP_AND, OP_OR, OP_XOR, OP_ADD, OP_ADDU, OP_SLT, OP_SLTU:
				rd = is_special ? rd_field : rt;
			OP_NOR, OP_SUB, OP_SUBU, OP_CLZ, OP_CLO, OP_JALR,
			OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV:
				rd = rd_field;
			default: rd = '0;
		endcase
	end

	always_comb begin
		case (op)
			OP_AND, OP_OR, OP_XOR, OP_LUI: imm = {16'b0, instruction[15:0]};
			// jump index
			OP_J, OP_JAL: imm = {6'b0, instruction[25:0]};
			default: imm = {{16{instruction[15]}}, instruction[15:0]};
		endcase
	end

	assign decoded.op       = op;
	assign decoded.rd       = rd;
	assign decoded.imm      = imm;
	assign decoded.shamt    = instruction[10:6];
	assign decoded.is_load  = (op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW});
	assign decoded.is_store = (op inside {OP_SB, OP_SH, OP_SW});
	assign decoded.is_priv  = (op == OP_ERET);
	assign decoded.link     = (op inside {OP_JAL, OP_JALR, OP_BLTZAL, OP_BGEZAL});

endmodule

`default_nettype wire

// File: hw/branch_resolver.sv
`default_nettype none
`timescale 1ns/10ps

module branch_resolver (
	input  cpu_pkg::uint32_t          reg1,
	input  cpu_pkg::uint32_t          reg2,
	input  cpu_pkg::uint32_t          pc,
	input  cpu_pkg::decoded_t         decoded,
	output cpu_pkg::branch_resolved_t resolved_branch
);
	import cpu_pkg::*;

	uint32_t pc_next, branch_target, jump_target;
	logic reg1_lez;

	// targets are relative to the delay slot
	assign pc_next       = pc + 32'd4;
	assign branch_target = pc_next + {decoded.imm[29:0], 2'b00};
	assign jump_target   = {pc_next[31:28], decoded.imm[25:0], 2'b00};
	assign reg1_lez      = reg1[31] | (reg1 == '0);

	always_comb begin
		resolved_branch.taken  = 1'b0;
		resolved_branch.target = '0;
		case (decoded.op)
			OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ,
			OP_BLTZ, OP_BGEZ, OP_BLTZAL, OP_BGEZAL:
				resolved_branch.target = branch_target;
			OP_J, OP_JAL: resolved_branch.target = jump_target;
			OP_JR, OP_JALR: resolved_branch.target = reg1;
			default: resolved_branch.target = '0;
		endcase
		case (decoded.op)
			OP_BEQ: resolved_branch.taken = (reg1 == reg2);
			OP_BNE: resolved_branch.taken = (reg1 != reg2);
			OP_BLEZ: resolved_branch.taken = reg1_lez;
			OP_BGTZ: resolved_branch.taken = ~reg1_lez;
			OP_BLTZ, OP_BLTZAL: resolved_branch.taken = reg1[31];
			OP_BGEZ, OP_BGEZAL: resolved_branch.taken = ~reg1[31];
			OP_J, OP_JAL, OP_JR, OP_JALR: resolved_branch.taken = 1'b1;
			default: resolved_branch.taken = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: hw/instr_exec.sv
`default_nettype none
`timescale 1ns/10ps

module instr_exec #(
	parameter bit has_count_leading = 1'b1
) (
	input  cpu_pkg::exec_req_t    req,
	input  cpu_pkg::decoded_t     decoded,
	output cpu_pkg::exec_result_t result
);
	import cpu_pkg::*;

	oper_t op;
	uint32_t reg1, reg2, alu_b, add_u, sub_u, exec_ret;
	uint32_t clz_cnt, clo_cnt, mem_vaddr, mem_wrdata;
	byte_en_t mem_sel;
	exception_t ex;
	logic ov_add, ov_sub, signed_lt, unsigned_lt, daddr_unaligned;

	assign op   = decoded.op;
	assign reg1 = req.reg1;
	assign reg2 = req.reg2;
	// immediate forms take the decoded immediate
	assign alu_b = (req.instruction[31:26] == 6'h00) ? reg2 : decoded.imm;

	assign add_u  = reg1 + alu_b;
	assign sub_u  = reg1 - alu_b;
	assign ov_add = (reg1[31] == alu_b[31]) & (reg1[31] ^ add_u[31]);
	assign ov_sub = (reg1[31] ^ alu_b[31]) & (reg1[31] ^ sub_u[31]);
	assign signed_lt   = (reg1[31] != alu_b[31]) ? reg1[31] : sub_u[31];
	assign unsigned_lt = (reg1 < alu_b);

	generate
		if (has_count_leading) begin : gen_count
			count_bit u_clz (.bit_val(1'b0), .val(reg1), .count(clz_cnt));
			count_bit u_clo (.bit_val(1'b1), .val(reg1), .count(clo_cnt));
		end else begin : gen_no_count
			assign clz_cnt = '0;
			assign clo_cnt = '0;
		end
	endgenerate

	always_comb begin
		case (op)
			OP_LUI: exec_ret = {decoded.imm[15:0], 16'b0};
			OP_AND: exec_ret = reg1 & alu_b;
			OP_OR: exec_ret = reg1 | alu_b;
			OP_XOR: exec_ret = reg1 ^ alu_b;
			OP_NOR: exec_ret = ~(reg1 | alu_b);
			OP_ADD, OP_ADDU: exec_ret = add_u;
			OP_SUB, OP_SUBU: exec_ret = sub_u;
			OP_SLT: exec_ret = {31'b0, signed_lt};
			OP_SLTU: exec_ret = {31'b0, unsigned_lt};
			OP_CLZ: exec_ret = clz_cnt;
			OP_CLO: exec_ret = clo_cnt;
			OP_SLL: exec_ret = reg2 << decoded.shamt;
			OP_SRL: exec_ret = reg2 >> decoded.shamt;
			OP_SRA: exec_ret = $signed(reg2) >>> decoded.shamt;
			OP_SLLV: exec_ret = reg2 << reg1[4:0];
			OP_SRLV: exec_ret = reg2 >> reg1[4:0];
			OP_SRAV: exec_ret = $signed(reg2) >>> reg1[4:0];
			default: exec_ret = '0;
		endcase
		// return address skips the delay slot
		if (decoded.link)
			exec_ret = req.pc + 32'd8;
	end

	assign mem_vaddr = reg1 + decoded.imm;

	always_comb begin
		case (op)
			OP_LW, OP_SW: begin
				mem_wrdata = reg2;
				mem_sel    = 4'b1111;
			end
			OP_LB, OP_LBU, OP_SB: begin
				mem_wrdata = reg2 << {mem_vaddr[1:0], 3'b000};
				mem_sel    = 4'b0001 << mem_vaddr[1:0];
			end
			OP_LH, OP_LHU, OP_SH: begin
				mem_wrdata = mem_vaddr[1] ? (reg2 << 16) : reg2;
				mem_sel    = mem_vaddr[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				mem_wrdata = '0;
				mem_sel    = '0;
			end
		endcase
		case (op)
			OP_LW, OP_SW: daddr_unaligned = |mem_vaddr[1:0];
			OP_LH, OP_LHU, OP_SH: daddr_unaligned = mem_vaddr[0];
			default: daddr_unaligned = 1'b0;
		endcase
	end

	// fetch, decode, execute, then memory faults
	always_comb begin
		ex = '0;
		ex.valid = 1'b1;
		if (|req.pc[1:0]) begin
			ex.exc_code = EXC_ADEL;
			ex.badvaddr = req.pc;
		end else if (op == OP_INVALID)
			ex.exc_code = EXC_RI;
		else if (op == OP_SYSCALL)
			ex.exc_code = EXC_SYS;
		else if (op == OP_BREAK)
			ex.exc_code = EXC_BP;
		else if ((op == OP_ADD && ov_add) || (op == OP_SUB && ov_sub))
			ex.exc_code = EXC_OV;
		else if (decoded.is_priv && req.is_usermode)
			ex.exc_code = EXC_CPU;
		else if (daddr_unaligned) begin
			ex.exc_code = decoded.is_load ? EXC_ADEL : EXC_ADES;
			ex.badvaddr = mem_vaddr;
		end else
			ex = '0;
	end

	assign result.valid  = 1'b1;
	assign result.result = exec_ret;
	assign result.rd     = decoded.rd;
	assign result.eret   = (op == OP_ERET) & ~ex.valid;
	assign result.memreq.read       = decoded.is_load & ~ex.valid;
	assign result.memreq.write      = decoded.is_store & ~ex.valid;
	assign result.memreq.vaddr      = mem_vaddr;
	assign result.memreq.wrdata     = mem_wrdata;
	assign result.memreq.byteenable = mem_sel;
	assign result.ex     = ex;
	// filled in by the branch resolver at the top
	assign result.branch = '0;

endmodule

`default_nettype wire

// File: hw/exec_result_stage.sv
`default_nettype none
`timescale 1ns/10ps

module exec_result_stage (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  req,
	input  cpu_pkg::exec_result_t next_result,
	output logic                  ack,
	output cpu_pkg::exec_result_t result
);
	import cpu_pkg::*;

	stage_state_t state;
	exec_result_t payload;
	logic valid_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= IDLE;
			ack     <= 1'b0;
			valid_q <= 1'b0;
		end else begin
			case (state)
				IDLE: begin
					if (req) begin
						state   <= HOLD;
						ack     <= 1'b1;
						valid_q <= 1'b1;
					end
				end
				// wait for the host to drop req
				HOLD: begin
					if (!req) begin
						state <= IDLE;
						ack   <= 1'b0;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && req)
			payload <= next_result;
	end

	always_comb begin
		result       = payload;
		result.valid = valid_q;
	end

endmodule

`default_nettype wire

// File: hw/exec_unit_top.sv
`default_nettype none
`timescale 1ns/10ps

module exec_unit_top #(
	parameter bit has_count_leading = 1'b1
) (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  req,
	input  cpu_pkg::exec_req_t    request,
	output logic                  ack,
	output cpu_pkg::exec_result_t result
);
	import cpu_pkg::*;

	decoded_t decoded;
	exec_result_t exec_result, next_result;
	branch_resolved_t resolved_branch;

	instr_decode u_decode (
		.instruction (request.instruction),
		.decoded     (decoded)
	);

	instr_exec #(
		.has_count_leading (has_count_leading)
	) u_exec (
		.req     (request),
		.decoded (decoded),
		.result  (exec_result)
	);

	branch_resolver u_branch (
		.reg1            (request.reg1),
		.reg2            (request.reg2),
		.pc              (request.pc),
		.decoded         (decoded),
		.resolved_branch (resolved_branch)
	);

	// execute record with the branch decision merged in
	assign next_result = '{
		valid:  exec_result.valid,
		result: exec_result.result,
		rd:     exec_result.rd,
		eret:   exec_result.eret,
		memreq: exec_result.memreq,
		ex:     exec_result.ex,
		branch: resolved_branch
	};

	exec_result_stage u_result (
		.clk         (clk),
		.reset       (reset),
		.req         (req),
		.next_result (next_result),
		.ack         (ack),
		.result      (result)
	);

endmodule

`default_nettype wire

// File: dv/exec_unit_tb.sv
`default_nettype none
`timescale 1ns/10ps

module exec_unit_tb;
	import cpu_pkg::*;

	localparam int n_alu = 40;
	localparam int n_imm = 10;
	localparam int n_clz = 12;
	localparam int n_br_reps = 4;
	localparam int n_trans = 1 + n_alu + 4 + n_imm + 2 * (n_clz + 2) + 32 + 12 * n_br_reps + 8;
	localparam int watchdog_cycles = n_trans * 10 + 10;

	localparam logic [5:0] alu_functs [16] = '{6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07,
		6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b};
	// addiu, andi, ori, xori, lui
	localparam logic [5:0] imm_ops [5] = '{6'h09, 6'h0c, 6'h0d, 6'h0e, 6'h0f};
	localparam logic [5:0] mem_ops [8] = '{6'h20, 6'h21, 6'h23, 6'h24, 6'h25,
		6'h28, 6'h29, 6'h2b};

	logic clk;
	logic reset;
	logic req;
	exec_req_t request;
	logic ack;
	exec_result_t result;

	exec_result_t got;
	logic [31:0] rng_state;
	logic [31:0] pick, tmp, a, b, pc;
	string test_name;
	int test_checks, test_errs;
	int tests_run, total_checks, total_errs;

	exec_unit_top #(
		.has_count_leading (1'b1)
	) UUT (
		.clk     (clk),
		.reset   (reset),
		.req     (req),
		.request (request),
		.ack     (ack),
		.result  (result)
	);

	always #20 clk = ~clk;

	function automatic logic [31:0] rand_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	function automatic logic [31:0] alu_ref(input logic [5:0] funct, input logic [31:0] x,
			input logic [31:0] y, input logic [4:0] sa);
		case (funct)
			6'h00: return y << sa;
			6'h02: return y >> sa;
			6'h03: return $signed(y) >>> sa;
			6'h04: return y << x[4:0];
			6'h06: return y >> x[4:0];
			6'h07: return $signed(y) >>> x[4:0];
			6'h20, 6'h21: return x + y;
			6'h22, 6'h23: return x - y;
			6'h24: return x & y;
			6'h25: return x | y;
			6'h26: return x ^ y;
			6'h27: return ~(x | y);
			6'h2a: return {31'b0, $signed(x) < $signed(y)};
			6'h2b: return {31'b0, x < y};
			default: return 32'h0;
		endcase
	endfunction

	// true result outside the signed 32-bit range
	function automatic logic add_overflows(input logic [31:0] x, input logic [31:0] y,
			input logic subtract);
		longint sx, sy, r;
		sx = longint'($signed(x));
		sy = longint'($signed(y));
		r = subtract ? sx - sy : sx + sy;
		return (r > 64'sd2147483647) || (r < -64'sd2147483648);
	endfunction

	function automatic logic [31:0] leading_count(input logic [31:0] v, input logic bitv);
		int n;
		n = 0;
		for (int i = 31; i >= 0; i--) begin
			if (v[i] != bitv)
				break;
			n++;
		end
		return 32'(n);
	endfunction

	task automatic begin_test(input string name);
		test_name = name;
		test_checks = 0;
		test_errs = 0;
	endtask

	task automatic end_test();
		$display("test %-14s %4d checks, %0d errors", test_name, test_checks, test_errs);
		tests_run++;
		total_checks += test_checks;
		total_errs += test_errs;
	endtask

	task automatic expect_val(input string what, input logic [31:0] want,
			input logic [31:0] act);
		test_checks++;
		assert (act === want) else begin
			$display("ERR %s %s: expected %h actual %h", test_name, what, want, act);
			test_errs++;
		end
	endtask

	task automatic expect_exc(input logic valid, input logic [4:0] code,
			input logic [31:0] bad);
		expect_val("ex.valid", 32'(valid), 32'(got.ex.valid));
		if (valid) begin
			expect_val("exc_code", 32'(code), 32'(got.ex.exc_code));
			if (code == EXC_ADEL || code == EXC_ADES)
				expect_val("badvaddr", bad, got.ex.badvaddr);
		end
	endtask

	// one four-phase transfer, result left in got
	task automatic issue(input logic [31:0] instr, input logic [31:0] fetch_pc,
			input logic [31:0] x, input logic [31:0] y, input logic user);
		int waited;
		@(negedge clk);
		request.instruction = instr;
		request.pc = fetch_pc;
		request.reg1 = x;
		request.reg2 = y;
		request.is_usermode = user;
		req = 1'b1;
		waited = 0;
		do begin
			@(negedge clk);
			waited++;
		end while (!ack && waited < 8);
		assert (ack) else begin
			$display("%s: ack did not rise within 8 cycles of req", test_name);
			test_errs++;
		end
		got = result;
		req = 1'b0;
		waited = 0;
		while (ack && waited < 8) begin
			@(negedge clk);
			waited++;
		end
		assert (!ack) else begin
			$display("%s: ack still high 8 cycles after req dropped", test_name);
			test_errs++;
		end
	endtask

	task automatic run_alu(input logic [5:0] funct, input logic [31:0] x, input logic [31:0] y,
			input logic [4:0] rdf, input logic [4:0] sa);
		logic ovf;
		issue({6'h00, 5'd1, 5'd2, rdf, sa, funct}, 32'h0000_4000, x, y, 1'b0);
		ovf = (funct == 6'h20 && add_overflows(x, y, 1'b0)) ||
			(funct == 6'h22 && add_overflows(x, y, 1'b1));
		expect_val("result", alu_ref(funct, x, y, sa), got.result);
		expect_val("rd", 32'(rdf), 32'(got.rd));
		expect_exc(ovf, EXC_OV, 32'h0);
		expect_val("memreq read/write", 32'h0, {30'b0, got.memreq.read, got.memreq.write});
	endtask

	task automatic run_imm(input logic [5:0] opc, input logic [31:0] x, input logic [15:0] imm16);
		logic [31:0] sext, zext, want;
		sext = {{16{imm16[15]}}, imm16};
		zext = {16'h0, imm16};
		case (opc)
			6'h09: want = x + sext;
			6'h0c: want = x & zext;
			6'h0d: want = x | zext;
			6'h0e: want = x ^ zext;
			default: want = {imm16, 16'h0};
		endcase
		issue({opc, 5'd3, 5'd7, imm16}, 32'h0000_4100, x, 32'hdead_beef, 1'b0);
		expect_val("imm result", want, got.result);
		expect_val("imm rd", 32'd7, 32'(got.rd));
		expect_exc(1'b0, EXC_OV, 32'h0);
	endtask

	task automatic run_count(input logic [31:0] v);
		issue({6'h1c, 5'd1, 5'd0, 5'd4, 5'd0, 6'h20}, 32'h0000_4200, v, 32'h0, 1'b0);
		expect_val("clz", leading_count(v, 1'b0), got.result);
		issue({6'h1c, 5'd1, 5'd0, 5'd4, 5'd0, 6'h21}, 32'h0000_4204, v, 32'h0, 1'b0);
		expect_val("clo", leading_count(v, 1'b1), got.result);
	endtask

	task automatic run_mem(input logic [5:0] opc, input logic [31:0] base,
			input logic [15:0] imm16, input logic [31:0] data);
		logic [31:0] addr, lanes, size_mask;
		logic store, mis;
		logic [3:0] be;
		addr = base + {{16{imm16[15]}}, imm16};
		store = opc[3];
		case (opc[1:0])
			2'b00: begin
				mis = 1'b0;
				size_mask = 32'h0000_00ff;
			end
			2'b01: begin
				mis = addr[0];
				size_mask = 32'h0000_ffff;
			end
			default: begin
				mis = |addr[1:0];
				size_mask = 32'hffff_ffff;
			end
		endcase
		// byte lanes of the access moved to its offset
		be = {size_mask[24], size_mask[16], size_mask[8], size_mask[0]} << addr[1:0];
		lanes = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
		issue({opc, 5'd2, 5'd5, imm16}, 32'h0000_4300, base, data, 1'b0);
		expect_val("vaddr", addr, got.memreq.vaddr);
		expect_val("read", 32'(!store && !mis), 32'(got.memreq.read));
		expect_val("write", 32'(store && !mis), 32'(got.memreq.write));
		expect_exc(mis, store ? 5'(EXC_ADES) : 5'(EXC_ADEL), addr);
		if (!mis)
			expect_val("byteenable", 32'(be), 32'(got.memreq.byteenable));
		if (store && !mis)
			expect_val("wrdata lanes", (data & size_mask) << {addr[1:0], 3'b000},
				got.memreq.wrdata & lanes);
		if (!store)
			expect_val("load rd", 32'd5, 32'(got.rd));
	endtask

	task automatic run_branch(input int kind, input logic [31:0] x, input logic [31:0] y,
			input logic [31:0] fetch_pc, input logic [25:0] idx);
		logic [31:0] seq, instr, target;
		logic taken, link;
		logic [4:0] link_rd;
		seq = fetch_pc + 32'd4;
		target = seq + {{14{idx[15]}}, idx[15:0], 2'b00};
		case (kind)
			0: instr = {6'h04, 5'd1, 5'd2, idx[15:0]};
			1: instr = {6'h05, 5'd1, 5'd2, idx[15:0]};
			2: instr = {6'h06, 5'd1, 5'd0, idx[15:0]};
			3: instr = {6'h07, 5'd1, 5'd0, idx[15:0]};
			4: instr = {6'h01, 5'd1, 5'h00, idx[15:0]};
			5: instr = {6'h01, 5'd1, 5'h01, idx[15:0]};
			6: instr = {6'h01, 5'd1, 5'h10, idx[15:0]};
			7: instr = {6'h01, 5'd1, 5'h11, idx[15:0]};
			8: instr = {6'h02, idx};
			9: instr = {6'h03, idx};
			10: instr = {6'h00, 5'd1, 15'h0, 6'h08};
			default: instr = {6'h00, 5'd1, 5'd0, 5'd12, 5'd0, 6'h09};
		endcase
		case (kind)
			0: taken = (x == y);
			1: taken = (x != y);
			2: taken = ($signed(x) <= 0);
			3: taken = ($signed(x) > 0);
			4, 6: taken = ($signed(x) < 0);
			5, 7: taken = ($signed(x) >= 0);
			default: taken = 1'b1;
		endcase
		if (kind == 8 || kind == 9)
			target = {seq[31:28], idx, 2'b00};
		else if (kind >= 10)
			target = x;
		link = (kind == 6 || kind == 7 || kind == 9 || kind == 11);
		link_rd = (kind == 11) ? 5'd12 : 5'd31;
		issue(instr, fetch_pc, x, y, 1'b0);
		expect_val("taken", 32'(taken), 32'(got.branch.taken));
		expect_val("target", target, got.branch.target);
		expect_exc(1'b0, 5'h0, 32'h0);
		if (link) begin
			expect_val("link rd", 32'(link_rd), 32'(got.rd));
			expect_val("link result", fetch_pc + 32'd8, got.result);
		end
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		req = 1'b0;
		request = '0;
		rng_state = 32'hab19_935b;
		tests_run = 0;
		total_checks = 0;
		total_errs = 0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		begin_test("handshake");
		expect_val("ack after reset", 32'h0, 32'(ack));
		expect_val("valid after reset", 32'h0, 32'(result.valid));
		request.instruction = {6'h00, 5'd1, 5'd2, 5'd3, 5'd0, 6'h21};
		request.pc = 32'h0000_0100;
		request.reg1 = 32'd5;
		request.reg2 = 32'd7;
		req = 1'b1;
		@(negedge clk);
		expect_val("ack one cycle after req", 32'h1, 32'(ack));
		expect_val("valid with ack", 32'h1, 32'(result.valid));
		expect_val("addu result", 32'd12, result.result);
		// host keeps req up a while longer
		repeat (3) begin
			@(negedge clk);
			expect_val("ack held with req", 32'h1, 32'(ack));
		end
		req = 1'b0;
		@(negedge clk);
		expect_val("ack after req drops", 32'h0, 32'(ack));
		end_test();

		begin_test("alu");
		for (int i = 0; i < n_alu; i++) begin
			pick = rand_next();
			a = rand_next();
			b = rand_next();
			run_alu(alu_functs[pick[31:28]], a, b, pick[20:16], pick[12:8]);
		end
		// signed range limits
		run_alu(6'h20, 32'h7fff_ffff, 32'h1, 5'd3, 5'd0);
		run_alu(6'h22, 32'h8000_0000, 32'h1, 5'd3, 5'd0);
		run_alu(6'h21, 32'h7fff_ffff, 32'h1, 5'd3, 5'd0);
		run_alu(6'h23, 32'h8000_0000, 32'h1, 5'd3, 5'd0);
		for (int i = 0; i < n_imm; i++) begin
			pick = rand_next();
			run_imm(imm_ops[i % 5], rand_next(), pick[31:16]);
		end
		end_test();

		begin_test("count_leading");
		run_count(32'h0);
		run_count(32'hffff_ffff);
		for (int i = 0; i < n_clz; i++) begin
			pick = rand_next();
			a = rand_next() >> pick[31:27];
			run_count(pick[0] ? ~a : a);
		end
		end_test();

		begin_test("memory");
		for (int i = 0; i < 8; i++) begin
			for (int k = 0; k < 4; k++) begin
				pick = rand_next();
				tmp = rand_next();
				run_mem(mem_ops[i], {pick[31:2], 2'b00}, {tmp[31:18], k[1:0]}, rand_next());
			end
		end
		end_test();

		begin_test("branches");
		for (int rep = 0; rep < n_br_reps; rep++) begin
			for (int kind = 0; kind < 12; kind++) begin
				pick = rand_next();
				a = (pick[31:30] == 2'b00) ? 32'h0 : rand_next();
				b = pick[29] ? a : rand_next();
				tmp = rand_next();
				pc = {tmp[31:2], 2'b00};
				tmp = rand_next();
				run_branch(kind, a, b, pc, tmp[31:6]);
			end
		end
		end_test();

		begin_test("exceptions");
		tmp = rand_next();
		pc = {tmp[31:2], 2'b10};
		issue(32'h0000_000c, pc, 32'h0, 32'h0, 1'b0);
		expect_exc(1'b1, EXC_ADEL, pc);
		// fetch fault on a load
		pc = {tmp[31:2], 2'b01};
		issue({6'h23, 5'd1, 5'd2, 16'h0010}, pc, 32'h0000_1000, 32'h0, 1'b0);
		expect_exc(1'b1, EXC_ADEL, pc);
		expect_val("read on fault", 32'h0, 32'(got.memreq.read));
		issue(32'hfc00_0000, 32'h0000_5000, 32'h0, 32'h0, 1'b0);
		expect_exc(1'b1, EXC_RI, 32'h0);
		// mfc0 is not supported
		issue(32'h4000_0000, 32'h0000_5004, 32'h0, 32'h0, 1'b0);
		expect_exc(1'b1, EXC_RI, 32'h0);
		issue(32'h0000_000c, 32'h0000_5008, 32'h0, 32'h0, 1'b0);
		expect_exc(1'b1, EXC_SYS, 32'h0);
		issue(32'h0000_000d, 32'h0000_500c, 32'h0, 32'h0, 1'b0);
		expect_exc(1'b1, EXC_BP, 32'h0);
		issue(32'h4200_0018, 32'h0000_5010, 32'h0, 32'h0, 1'b1);
		expect_exc(1'b1, EXC_CPU, 32'h0);
		expect_val("eret in user mode", 32'h0, 32'(got.eret));
		issue(32'h4200_0018, 32'h0000_5014, 32'h0, 32'h0, 1'b0);
		expect_exc(1'b0, 5'h0, 32'h0);
		expect_val("eret in kernel mode", 32'h1, 32'(got.eret));
		end_test();

		$display("%0d tests, %0d checks, %0d errors", tests_run, total_checks, total_errs);
		if (total_errs == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("watchdog: run exceeded %0d cycles, DUT stopped responding", watchdog_cycles);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
hw/cpu_pkg.sv
hw/count_bit.sv
hw/instr_decode.sv
hw/branch_resolver.sv
hw/instr_exec.sv
hw/exec_result_stage.sv
hw/exec_unit_top.sv
dv/exec_unit_tb.sv

// File: run.sh
#!/bin/sh
# builds the execute unit testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module exec_unit_tb -f list.f || exit 1
out=$(./obj_dir/Vexec_unit_tb)
echo "$out"
echo "$out" | grep -qx "TEST RESULT: PASS" && exit 0 || exit 1
